// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported RV32I instructions
    localparam logic [6:0] LUI   = 7'b0110111;
    localparam logic [6:0] AUIPC = 7'b0010111;
    localparam logic [6:0] JAL   = 7'b1101111;
    localparam logic [6:0] JALR  = 7'b1100111;
    localparam logic [6:0] I_ALU = 7'b0010011;
    localparam logic [6:0] R_ALU = 7'b0110011;

    // funct3 field of the ALU groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA as selected by inst[30]
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASS2 = 4'd10 // Forwards operand 2 for LUI
    } alu_op_e;

    // Decoded instruction handed from decode to execute
    typedef struct packed {
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] imm;  // Kept apart from src2 for the jump target
        alu_op_e         alu_op;
        logic [4:0]      rd;
        logic            wen;
        logic            jump;
        logic            jalr;
    } dec_t;

    // Register writeback record
    typedef struct packed {
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/idu.sv ====
`timescale 1ns/100ps
`default_nettype none

module idu (
    input  logic [31:0]  inst,
    input  logic [31:0]  pc,
    input  logic [31:0]  rs1_data,
    input  logic [31:0]  rs2_data,
    output logic [4:0]   rs1_addr,
    output logic [4:0]   rs2_addr,
    output rv_pkg::dec_t dec
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;      // inst[30] selects SUB and SRA
    logic [31:0]     imm;
    logic [1:0]      src1_sel;
    rv_pkg::alu_op_e alu_op;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign alt      = inst[30];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // Sign-extended immediate per format
    always_comb begin
        case (opcode)
            rv_pkg::I_ALU, rv_pkg::JALR:
                imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::JAL:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            rv_pkg::LUI, rv_pkg::AUIPC:
                imm = {inst[31:12], 12'b0};
            default:
                imm = 32'h0;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::LUI:               src1_sel = 2'b00; // Zero
            rv_pkg::AUIPC, rv_pkg::JAL: src1_sel = 2'b01; // PC
            default:                   src1_sel = 2'b10; // rs1
        endcase
    end

    // The shift amount of SLLI, SRLI and SRAI sits in imm[4:0]
    always_comb begin
        case (opcode)
            rv_pkg::LUI: begin
                alu_op = rv_pkg::PASS2;
            end
            rv_pkg::I_ALU, rv_pkg::R_ALU: begin
                case (funct3)
                    rv_pkg::F3_ADD_SUB:
                        alu_op = (opcode == rv_pkg::R_ALU && alt) ? rv_pkg::SUB : rv_pkg::ADD;
                    rv_pkg::F3_SLL:  alu_op = rv_pkg::SLL;
                    rv_pkg::F3_SLT:  alu_op = rv_pkg::SLT;
                    rv_pkg::F3_SLTU: alu_op = rv_pkg::SLTU;
                    rv_pkg::F3_XOR:  alu_op = rv_pkg::XOR;
                    rv_pkg::F3_SR:   alu_op = alt ? rv_pkg::SRA : rv_pkg::SRL;
                    rv_pkg::F3_OR:   alu_op = rv_pkg::OR;
                    default:         alu_op = rv_pkg::AND;
                endcase
            end
            default: begin
                alu_op = rv_pkg::ADD; // AUIPC, JAL and JALR all add
            end
        endcase
    end

    always_comb begin
        dec.src1   = src1_sel[1] ? rs1_data : (src1_sel[0] ? pc : 32'h0);
        dec.src2   = (opcode == rv_pkg::R_ALU) ? rs2_data : imm;
        dec.imm    = imm;
        dec.alu_op = alu_op;
        dec.rd     = inst[11:7];
        dec.jump   = 1'b0;
        dec.jalr   = 1'b0;
        dec.wen    = 1'b0;
        case (opcode)
            rv_pkg::LUI, rv_pkg::AUIPC, rv_pkg::I_ALU, rv_pkg::R_ALU: begin
                dec.wen = 1'b1;
            end
            rv_pkg::JAL: begin
                dec.wen  = 1'b1;
                dec.jump = 1'b1;
            end
            rv_pkg::JALR: begin
                dec.wen  = 1'b1;
                dec.jump = 1'b1;
                dec.jalr = 1'b1;
            end
            default: begin
                dec.wen = 1'b0; // Unsupported opcodes retire as no-ops
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [4:0]   rs1_addr,
    input  logic [4:0]   rs2_addr,
    input  rv_pkg::wb_t  wb,
    output logic [31:0]  rs1_data,
    output logic [31:0]  rs2_data
);
    // x0 has no storage and always reads as zero
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (wb.wen && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Reads see the state before this cycle's write
    assign rs1_data = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu (
    input  rv_pkg::dec_t dec,
    input  logic [31:0]  pc,
    output rv_pkg::wb_t  wb,
    output logic [31:0]  jump_target
);
    logic [4:0]  shamt;
    logic [31:0] alu_out;
    logic [31:0] target_sum;
    logic [31:0] link;

    assign shamt = dec.src2[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ADD:   alu_out = dec.src1 + dec.src2;
            rv_pkg::SUB:   alu_out = dec.src1 - dec.src2;
            rv_pkg::SLL:   alu_out = dec.src1 << shamt;
            rv_pkg::SLT:   alu_out = {31'b0, $signed(dec.src1) < $signed(dec.src2)};
            rv_pkg::SLTU:  alu_out = {31'b0, dec.src1 < dec.src2};
            rv_pkg::XOR:   alu_out = dec.src1 ^ dec.src2;
            rv_pkg::SRL:   alu_out = dec.src1 >> shamt;
            rv_pkg::SRA:   alu_out = 32'($signed(dec.src1) >>> shamt);
            rv_pkg::OR:    alu_out = dec.src1 | dec.src2;
            rv_pkg::AND:   alu_out = dec.src1 & dec.src2;
            rv_pkg::PASS2: alu_out = dec.src2;
            default:       alu_out = 32'h0;
        endcase
    end

    // JAL gets pc as src1 and JALR gets rs1
    assign target_sum  = dec.src1 + dec.imm;
    assign jump_target = dec.jalr ? {target_sum[31:1], 1'b0} : target_sum;

    assign link = pc + 32'd4;

    always_comb begin
        wb.wen  = dec.wen;
        wb.rd   = dec.rd;
        wb.data = dec.jump ? link : alu_out; // Jumps write the return address
    end

endmodule

`default_nettype wire

// ==== hdl/pc_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_reg #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        jump,
    input  logic [31:0] jump_target,
    output logic [31:0] pc
);
    logic [31:0] next_pc;

    assign next_pc = jump ? jump_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc; // One instruction retires every cycle
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst,  // Instruction memory data at pc in the same cycle
    output logic [31:0] pc,
    output rv_pkg::wb_t wb
);
    logic [4:0]   rs1_addr;
    logic [4:0]   rs2_addr;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic [31:0]  jump_target;
    rv_pkg::dec_t dec;

    pc_reg #(
        .RESET_PC    (RESET_PC)
    ) u_pc_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump        (dec.jump),
        .jump_target (jump_target),
        .pc          (pc)
    );

    idu u_idu (
        .inst        (inst),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .dec         (dec)
    );

    regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wb          (wb),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    exu u_exu (
        .dec         (dec),
        .pc          (pc),
        .wb          (wb),
        .jump_target (jump_target)
    );

endmodule

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
    localparam int NUM_STEPS    = 34;
    localparam int IMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_CYCLES  = 20; // Upper bound for every wait loop

    // One line of the golden file
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        rv_pkg::wb_t wb;
        logic [31:0] next_pc;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    rv_pkg::wb_t wb;

    logic [31:0] golden [0:NUM_STEPS*6-1]; // Six words per golden line
    logic [31:0] imem [0:IMEM_WORDS-1];
    logic        covered [0:IMEM_WORDS-1];
    step_t       steps [0:NUM_STEPS-1];
    integer      seed;

    rv_core #(
        .RESET_PC (32'h0000_0000)
    ) u_rv_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .pc       (pc),
        .wb       (wb)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0d ns, %s is %h but %h was expected",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_program();
        logic [5:0] slot;
        seed = 32'hca77_3b42;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i]    = $random(seed); // Filler that a correct core never fetches
            covered[i] = 1'b0;
        end
        $readmemh("dv/rv_golden.txt", golden);
        for (int s = 0; s < NUM_STEPS; s++) begin
            steps[s].pc      = golden[6*s];
            steps[s].inst    = golden[6*s+1];
            steps[s].wb.wen  = golden[6*s+2][0];
            steps[s].wb.rd   = golden[6*s+3][4:0];
            steps[s].wb.data = golden[6*s+4];
            steps[s].next_pc = golden[6*s+5];
            if (steps[s].pc[1:0] != 2'b00 || steps[s].pc >= 32'(IMEM_WORDS * 4)) begin
                abort_run($sformatf("Golden line %0d holds a PC outside instruction memory", s));
            end
            slot          = steps[s].pc[7:2];
            imem[slot]    = steps[s].inst;
            covered[slot] = 1'b1;
        end
    endtask

    task automatic reset_core();
        int cycles;
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
        end
        rst_n  = 1'b1; // Released on a falling edge ahead of the first fetch
        cycles = 0;
        while (pc !== 32'h0 && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== 32'h0) begin
            abort_run("Timed out waiting for the PC to reach the reset address");
        end
    endtask

    // Combinational instruction memory read at the current PC
    task automatic fetch();
        logic [5:0] slot;
        slot = pc[7:2];
        if (pc[1:0] != 2'b00 || pc >= 32'(IMEM_WORDS * 4) || !covered[slot]) begin
            abort_run($sformatf("error: time %0d ns, pc %h fetches a word outside the program",
                                $time, pc));
        end
        inst = imem[slot];
    endtask

    task automatic wait_pc_update();
        logic [31:0] old_pc;
        int          cycles;
        old_pc = pc;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (pc == old_pc && cycles < WAIT_CYCLES);
        if (pc == old_pc) begin
            abort_run("Timed out waiting for the PC to advance");
        end
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        inst  = 32'h0;
        load_program();
        reset_core();
        for (int s = 0; s < NUM_STEPS; s++) begin
            fetch();
            #10;
            check_value("wb.wen", 32'(wb.wen), 32'(steps[s].wb.wen));
            if (steps[s].wb.wen) begin
                check_value("wb.rd", 32'(wb.rd), 32'(steps[s].wb.rd));
                check_value("wb.data", wb.data, steps[s].wb.data);
            end
            wait_pc_update();
            check_value("next pc", pc, steps[s].next_pc);
            @(negedge clk);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rv_golden.txt ====
// Columns in hex: pc, instruction, write enable, rd, write data, next pc
// One executed instruction per line, in program order
00000000 00500093 1 01 00000005 00000004 // addi x1, x0, 5
00000004 ffd00113 1 02 fffffffd 00000008 // addi x2, x0, -3
00000008 002081b3 1 03 00000002 0000000c // add x3, x1, x2
0000000c 40110233 1 04 fffffff8 00000010 // sub x4, x2, x1
00000010 402082b3 1 05 00000008 00000014 // sub x5, x1, x2
00000014 40100333 1 06 fffffffb 00000018 // sub x6, x0, x1
00000018 001123b3 1 07 00000001 0000001c // slt x7, x2, x1
0000001c 00113433 1 08 00000000 00000020 // sltu x8, x2, x1
00000020 ffe12493 1 09 00000001 00000024 // slti x9, x2, -2
00000024 fff0b513 1 0a 00000001 00000028 // sltiu x10, x1, -1
00000028 0f014593 1 0b ffffff0d 0000002c // xori x11, x2, 0xf0
0000002c 7000e613 1 0c 00000705 00000030 // ori x12, x1, 0x700
00000030 07f17693 1 0d 0000007d 00000034 // andi x13, x2, 0x7f
00000034 00409713 1 0e 00000050 00000038 // slli x14, x1, 4
00000038 01c15793 1 0f 0000000f 0000003c // srli x15, x2, 28
0000003c 40115813 1 10 fffffffe 00000040 // srai x16, x2, 1
00000040 00e098b3 1 11 00050000 00000044 // sll x17, x1, x14
00000044 00115933 1 12 07ffffff 00000048 // srl x18, x2, x1
00000048 401159b3 1 13 ffffffff 0000004c // sra x19, x2, x1
0000004c 00c5ca33 1 14 fffff808 00000050 // xor x20, x11, x12
00000050 0100eab3 1 15 ffffffff 00000054 // or x21, x1, x16
00000054 00c5fb33 1 16 00000705 00000058 // and x22, x11, x12
00000058 12345bb7 1 17 12345000 0000005c // lui x23, 0x12345
0000005c 00001c17 1 18 0000105c 00000060 // auipc x24, 0x1
00000060 010000ef 1 01 00000064 00000070 // jal x1, +16
00000070 01d08ce7 1 19 00000074 00000080 // jalr x25, 29(x1) with bit 0 cleared
00000080 00708013 1 00 0000006b 00000084 // addi x0, x1, 7
00000084 00100d33 1 1a 00000064 00000088 // add x26, x0, x1
00000088 0000ad83 0 00 00000000 0000008c // lw x27, 0(x1) is a no-op here
0000008c 00000463 0 00 00000000 00000090 // beq x0, x0, +8 is a no-op here
00000090 000d8e33 1 1c 00000000 00000094 // add x28, x27, x0
00000094 000c8e93 1 1d 00000074 00000098 // addi x29, x25, 0
00000098 418b8f33 1 1e 12343fa4 0000009c // sub x30, x23, x24
0000009c 0020afb3 1 1f 00000000 000000a0 // slt x31, x1, x2

// ==== verilog.f ====
hdl/rv_pkg.sv
hdl/idu.sv
hdl/regfile.sv
hdl/exu.sv
hdl/pc_reg.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the core with its testbench in Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_core -f verilog.f \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vtb_rv_core 2>&1)"
echo "$sim_output"

echo "$sim_output" | grep -q "^Test OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
